//--- Bender.yml
package:
  name: imuldiv

sources:
  - include_dirs:
      - .
    files:
      - imuldiv_pkg.sv
      - imuldiv_mul_iterative.sv
      - imuldiv_div_iterative.sv
      - imuldiv_port_mux.sv
      - imuldiv_top.sv
      - target: test
        include_dirs:
          - .
        files:
          - imuldiv_checker.sv
          - imuldiv_tb.sv

//--- imuldiv_checker.sv
// ------------------------------
// testbench monitor for the multiply/divide subsystem
// predicts each result at the request handshake and compares at the response
// ------------------------------

`timescale 1ns/1ps
`include "imuldiv_consts.svh"

module imuldiv_checker (
  input  logic                     clk,
  input  logic                     reset,
  input  imuldiv_pkg::muldiv_op_e  req_op,
  input  logic [`IMULDIV_XLEN-1:0] req_a,
  input  logic [`IMULDIV_XLEN-1:0] req_b,
  input  logic                     req_val,
  input  logic                     req_rdy,
  input  imuldiv_pkg::muldiv_op_e  resp_op,
  input  logic [`IMULDIV_RLEN-1:0] resp_result,
  input  logic                     resp_val,
  input  logic                     resp_rdy,
  input  logic                     mul_done,
  input  logic                     div_done,
  output int                       resp_count,
  output int                       err_count
);

  // one outstanding operation as seen at the request port
  typedef struct packed {
    logic [31:0]              id;
    logic [1:0]               op;
    logic [`IMULDIV_XLEN-1:0] a;
    logic [`IMULDIV_XLEN-1:0] b;
    logic [`IMULDIV_RLEN-1:0] exp;
  } pend_t;

  // one queue per unit, each unit holds at most one operation
  pend_t mul_q[$];
  pend_t div_q[$];
  pend_t np;
  pend_t p;
  int    req_count;
  int    pass_count;
  logic  reset_q;
  // high when the last response came from the multiplier
  logic  last_mul;
  logic  got_mul;
  logic  ok;

  function automatic string op_text(input logic [1:0] op);
    if (op == imuldiv_pkg::OP_MUL) return "mul";
    if (op == imuldiv_pkg::OP_DIV) return "div";
    return "divu";
  endfunction

  // ------------------------------
  // expected result from the arithmetic rules
  // ------------------------------
  function automatic logic [`IMULDIV_RLEN-1:0] predict(input logic [1:0] op,
                                                     input logic [`IMULDIV_XLEN-1:0] a,
                                                     input logic [`IMULDIV_XLEN-1:0] b);
    longint sa;
    longint sb;
    longint q;
    longint r;
    sa = $signed(a);
    sb = $signed(b);
    // full 64-bit signed product
    if (op == imuldiv_pkg::OP_MUL) return sa * sb;
    // divide by zero, quotient all ones and remainder is the dividend
    if (b == '0) return {a, {`IMULDIV_XLEN{1'b1}}};
    if (op == imuldiv_pkg::OP_DIV) begin
      // truncating divide, remainder carries the dividend's sign
      q = sa / sb;
      r = sa % sb;
      return {r[31:0], q[31:0]};
    end
    return {a % b, a / b};
  endfunction

  always @(posedge clk) begin
    if (reset) begin
      mul_q.delete();
      div_q.delete();
      req_count  = 0;
      pass_count = 0;
      resp_count = 0;
      err_count  = 0;
      // pointer favors mul after reset, as if div went last
      last_mul   = 1'b0;
    end else begin
      // first cycle out of reset, both units idle
      if (reset_q) begin
        ok = 1'b1;
        if (req_rdy !== 1'b1) begin
          $display("[FAIL] req_rdy after reset got %h expected 1", req_rdy);
          ok = 1'b0;
        end
        if (resp_val !== 1'b0) begin
          $display("[FAIL] resp_val after reset got %h expected 0", resp_val);
          ok = 1'b0;
        end
        if (ok) begin
          pass_count = pass_count + 1;
          $display("test reset: req_rdy=1 resp_val=0 ok");
        end else begin
          err_count = err_count + 1;
        end
      end
      // request handshake, record the prediction for the steered unit
      if (req_val && req_rdy) begin
        np.id  = req_count;
        np.op  = req_op;
        np.a   = req_a;
        np.b   = req_b;
        np.exp = predict(req_op, req_a, req_b);
        req_count = req_count + 1;
        if (req_op == imuldiv_pkg::OP_MUL) mul_q.push_back(np);
        else div_q.push_back(np);
      end
      // response handshake
      if (resp_val && resp_rdy) begin
        resp_count = resp_count + 1;
        got_mul = (resp_op == imuldiv_pkg::OP_MUL);
        ok = 1'b1;
        // both done, the unit not granted last must win
        if (mul_done && div_done && (got_mul == last_mul)) begin
          $display("[FAIL] resp_op got %h expected %h with both units done",
                   resp_op, last_mul ? imuldiv_pkg::OP_DIV : imuldiv_pkg::OP_MUL);
          ok = 1'b0;
        end
        last_mul = got_mul;
        if ((got_mul && mul_q.size() == 0) || (!got_mul && div_q.size() == 0)) begin
          $display("unexpected response: %s result %h arrived with no request outstanding",
                   op_text(resp_op), resp_result);
          err_count = err_count + 1;
        end else begin
          if (got_mul) p = mul_q.pop_front();
          else p = div_q.pop_front();
          if (p.op != resp_op) begin
            $display("[FAIL] test %0d resp_op got %h expected %h", p.id, resp_op, p.op);
            ok = 1'b0;
          end
          if (resp_result !== p.exp) begin
            $display("[FAIL] test %0d resp_result got %h expected %h",
                     p.id, resp_result, p.exp);
            ok = 1'b0;
          end
          if (ok) begin
            pass_count = pass_count + 1;
            $display("test %0d %s a=%h b=%h result=%h ok",
                     p.id, op_text(p.op), p.a, p.b, resp_result);
          end else begin
            err_count = err_count + 1;
          end
        end
      end
    end
    reset_q = reset;
  end

  // ------------------------------
  // end of run, lost responses and the totals
  // ------------------------------
  task automatic report_summary();
    if (mul_q.size() != 0) begin
      $display("missing response: %0d multiply request(s) never answered", mul_q.size());
      err_count = err_count + mul_q.size();
    end
    if (div_q.size() != 0) begin
      $display("missing response: %0d divide request(s) never answered", div_q.size());
      err_count = err_count + div_q.size();
    end
    $display("summary: %0d requests, %0d responses, %0d tests passed, %0d errors",
             req_count, resp_count, pass_count, err_count);
  endtask

endmodule

//--- imuldiv_consts.svh
// ------------------------------
// width and iteration constants for the multiply/divide subsystem
// include in every RTL file that sizes operands, results or counters
// ------------------------------

`ifndef IMULDIV_CONSTS_SVH
`define IMULDIV_CONSTS_SVH

// operand width
`define IMULDIV_XLEN 32
// result width, product or {remainder, quotient}
`define IMULDIV_RLEN 64
// add/shift or subtract/shift steps per operation
`define IMULDIV_STEPS 32
// step counter width, holds IMULDIV_STEPS - 1
`define IMULDIV_CNT_W 5

`endif

//--- imuldiv_div_iterative.sv
// ------------------------------
// iterative restoring divider, signed or unsigned, with remainder
// result is {remainder, quotient}; one quotient bit per cycle
// ------------------------------

`timescale 1ns/1ps
`include "imuldiv_consts.svh"

module imuldiv_div_iterative (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     req_val,
  output logic                     req_rdy,
  input  logic [`IMULDIV_XLEN-1:0] req_a,
  input  logic [`IMULDIV_XLEN-1:0] req_b,
  input  logic                     div_signed,
  output logic                     resp_val,
  input  logic                     resp_rdy,
  output logic [`IMULDIV_RLEN-1:0] resp_result
);

  localparam int XL = `IMULDIV_XLEN;
  localparam logic [`IMULDIV_CNT_W-1:0] LAST_CNT = `IMULDIV_CNT_W'(`IMULDIV_STEPS - 1);

  imuldiv_pkg::unit_state_e state;
  imuldiv_pkg::unit_state_e state_next;

  logic [`IMULDIV_CNT_W-1:0] cnt;
  // remainder in the upper half, dividend bits shifting out of the lower half
  logic [`IMULDIV_RLEN-1:0]  rq;
  logic [XL-1:0]             divisor;
  logic                      q_neg;
  logic                      r_neg;

  logic          a_neg;
  logic          b_neg;
  logic [XL-1:0] a_mag;
  logic [XL-1:0] b_mag;
  logic [XL:0]   rem_sh;
  logic [XL+1:0] diff;
  logic [XL-1:0] quo;
  logic [XL-1:0] rem;
  logic          req_go;
  logic          resp_go;
  logic          last_step;

  // ------------------------------
  // control
  // ------------------------------

  assign req_rdy   = (state == imuldiv_pkg::ST_IDLE);
  assign resp_val  = (state == imuldiv_pkg::ST_DONE);
  assign req_go    = req_val && req_rdy;
  assign resp_go   = resp_val && resp_rdy;
  assign last_step = (state == imuldiv_pkg::ST_CALC) && (cnt == '0);

  always_comb begin
    state_next = state;
    case (state)
      imuldiv_pkg::ST_IDLE: if (req_go) state_next = imuldiv_pkg::ST_CALC;
      imuldiv_pkg::ST_CALC: if (last_step) state_next = imuldiv_pkg::ST_DONE;
      imuldiv_pkg::ST_DONE: if (resp_go) state_next = imuldiv_pkg::ST_IDLE;
      default: state_next = imuldiv_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= imuldiv_pkg::ST_IDLE;
      cnt   <= '0;
    end else begin
      state <= state_next;
      if (req_go) begin
        cnt <= LAST_CNT;
      end else if (state == imuldiv_pkg::ST_CALC) begin
        cnt <= cnt - 1'b1;
      end
    end
  end

  // ------------------------------
  // datapath
  // ------------------------------

  // sign bits only count for a signed divide
  assign a_neg = div_signed && req_a[XL-1];
  assign b_neg = div_signed && req_b[XL-1];
  assign a_mag = a_neg ? (~req_a + 1'b1) : req_a;
  assign b_mag = b_neg ? (~req_b + 1'b1) : req_b;

  // shifted partial remainder can reach 33 bits before the trial subtract
  assign rem_sh = rq[`IMULDIV_RLEN-1:XL-1];
  assign diff   = {1'b0, rem_sh} - {2'b0, divisor};

  always_ff @(posedge clk) begin
    if (req_go) begin
      rq      <= {{XL{1'b0}}, a_mag};
      divisor <= b_mag;
      // divide by zero keeps the all ones quotient whatever the signs
      q_neg   <= (a_neg ^ b_neg) && (req_b != '0);
      // remainder follows the dividend
      r_neg   <= a_neg;
    end else if (state == imuldiv_pkg::ST_CALC) begin
      if (!diff[XL+1]) begin
        // subtract fits, keep the difference and set the quotient bit
        rq <= {diff[XL-1:0], rq[XL-2:0], 1'b1};
      end else begin
        // restore
        rq <= {rem_sh[XL-1:0], rq[XL-2:0], 1'b0};
      end
    end
  end

  assign quo = q_neg ? (~rq[XL-1:0] + 1'b1) : rq[XL-1:0];
  assign rem = r_neg ? (~rq[`IMULDIV_RLEN-1:XL] + 1'b1) : rq[`IMULDIV_RLEN-1:XL];

  assign resp_result = {rem, quo};

endmodule

//--- imuldiv_mul_iterative.sv
// ------------------------------
// iterative signed multiplier, one add/shift step per cycle
// holds one operation; result waits in ST_DONE until taken
// ------------------------------

`timescale 1ns/1ps
`include "imuldiv_consts.svh"

module imuldiv_mul_iterative (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     req_val,
  output logic                     req_rdy,
  input  logic [`IMULDIV_XLEN-1:0] req_a,
  input  logic [`IMULDIV_XLEN-1:0] req_b,
  output logic                     resp_val,
  input  logic                     resp_rdy,
  output logic [`IMULDIV_RLEN-1:0] resp_result
);

  // counter starts here and runs down to zero, one step per value
  localparam logic [`IMULDIV_CNT_W-1:0] LAST_CNT = `IMULDIV_CNT_W'(`IMULDIV_STEPS - 1);

  imuldiv_pkg::unit_state_e state;
  imuldiv_pkg::unit_state_e state_next;

  logic [`IMULDIV_CNT_W-1:0] cnt;
  logic [`IMULDIV_RLEN-1:0]  a_reg;
  logic [`IMULDIV_XLEN-1:0]  b_reg;
  logic [`IMULDIV_RLEN-1:0]  acc;
  logic                      neg;

  logic [`IMULDIV_XLEN-1:0]  a_mag;
  logic [`IMULDIV_XLEN-1:0]  b_mag;
  logic                      req_go;
  logic                      resp_go;
  logic                      last_step;

  // ------------------------------
  // control
  // ------------------------------

  assign req_rdy   = (state == imuldiv_pkg::ST_IDLE);
  assign resp_val  = (state == imuldiv_pkg::ST_DONE);
  assign req_go    = req_val && req_rdy;
  assign resp_go   = resp_val && resp_rdy;
  assign last_step = (state == imuldiv_pkg::ST_CALC) && (cnt == '0);

  always_comb begin
    state_next = state;
    case (state)
      imuldiv_pkg::ST_IDLE: if (req_go) state_next = imuldiv_pkg::ST_CALC;
      imuldiv_pkg::ST_CALC: if (last_step) state_next = imuldiv_pkg::ST_DONE;
      imuldiv_pkg::ST_DONE: if (resp_go) state_next = imuldiv_pkg::ST_IDLE;
      default: state_next = imuldiv_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= imuldiv_pkg::ST_IDLE;
      cnt   <= '0;
    end else begin
      state <= state_next;
      // load on accept, count down through ST_CALC
      if (req_go) begin
        cnt <= LAST_CNT;
      end else if (state == imuldiv_pkg::ST_CALC) begin
        cnt <= cnt - 1'b1;
      end
    end
  end

  // ------------------------------
  // datapath
  // ------------------------------

  // operand magnitudes, two's complement negate when the sign bit is set
  assign a_mag = req_a[`IMULDIV_XLEN-1] ? (~req_a + 1'b1) : req_a;
  assign b_mag = req_b[`IMULDIV_XLEN-1] ? (~req_b + 1'b1) : req_b;

  always_ff @(posedge clk) begin
    if (req_go) begin
      a_reg <= {{(`IMULDIV_RLEN - `IMULDIV_XLEN){1'b0}}, a_mag};
      b_reg <= b_mag;
      acc   <= '0;
      // product is negative when exactly one operand is
      neg   <= req_a[`IMULDIV_XLEN-1] ^ req_b[`IMULDIV_XLEN-1];
    end else if (state == imuldiv_pkg::ST_CALC) begin
      if (b_reg[0]) begin
        acc <= acc + a_reg;
      end
      a_reg <= a_reg << 1;
      b_reg <= b_reg >> 1;
    end
  end

  // restore the sign on the way out
  assign resp_result = neg ? (~acc + 1'b1) : acc;

endmodule

//--- imuldiv_pkg.sv
// ------------------------------
// shared types for the multiply/divide subsystem
// opcode of the request port and the state of each iterative unit
// ------------------------------

package imuldiv_pkg;

  // request opcode, 2'd3 is unused
  typedef enum logic [1:0] {
    OP_MUL  = 2'd0,
    OP_DIV  = 2'd1,
    OP_DIVU = 2'd2
  } muldiv_op_e;

  // control state shared by the mul and div units
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_CALC = 2'd1,
    ST_DONE = 2'd2
  } unit_state_e;

endpackage

//--- imuldiv_port_mux.sv
// ------------------------------
// request steering by opcode and round-robin response arbitration
// sits between the external ports and the mul and div units
// ------------------------------

`timescale 1ns/1ps
`include "imuldiv_consts.svh"

module imuldiv_port_mux (
  input  logic                     clk,
  input  logic                     reset,
  input  imuldiv_pkg::muldiv_op_e  req_op,
  input  logic                     req_val,
  output logic                     req_rdy,
  output logic                     mul_req_val,
  input  logic                     mul_req_rdy,
  output logic                     div_req_val,
  input  logic                     div_req_rdy,
  output logic                     div_signed,
  input  logic                     mul_resp_val,
  input  logic [`IMULDIV_RLEN-1:0] mul_resp_result,
  output logic                     mul_resp_rdy,
  input  logic                     div_resp_val,
  input  logic [`IMULDIV_RLEN-1:0] div_resp_result,
  output logic                     div_resp_rdy,
  output logic                     resp_val,
  input  logic                     resp_rdy,
  output imuldiv_pkg::muldiv_op_e  resp_op,
  output logic [`IMULDIV_RLEN-1:0] resp_result
);

  logic is_mul;
  logic grant_mul;
  logic grant_div;
  // high when mul took the last response
  logic last_mul;
  // signedness of the divide held by the div unit
  logic div_signed_q;

  // ------------------------------
  // request side
  // ------------------------------

  // anything that is not a multiply goes to the divider
  assign is_mul      = (req_op == imuldiv_pkg::OP_MUL);
  assign div_signed  = (req_op == imuldiv_pkg::OP_DIV);
  assign mul_req_val = req_val && is_mul;
  assign div_req_val = req_val && !is_mul;
  assign req_rdy     = is_mul ? mul_req_rdy : div_req_rdy;

  // ------------------------------
  // response side
  // ------------------------------

  // mul wins alone or when div had the last grant
  assign grant_mul = mul_resp_val && (!div_resp_val || !last_mul);
  assign grant_div = div_resp_val && !grant_mul;

  assign resp_val     = mul_resp_val || div_resp_val;
  assign resp_result  = grant_mul ? mul_resp_result : div_resp_result;
  assign mul_resp_rdy = resp_rdy && grant_mul;
  assign div_resp_rdy = resp_rdy && grant_div;

  always_comb begin
    if (grant_mul) begin
      resp_op = imuldiv_pkg::OP_MUL;
    end else if (div_signed_q) begin
      resp_op = imuldiv_pkg::OP_DIV;
    end else begin
      resp_op = imuldiv_pkg::OP_DIVU;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      last_mul     <= 1'b0;
      div_signed_q <= 1'b0;
    end else begin
      // pointer moves only on a transfer, so a stalled grant holds
      if (resp_val && resp_rdy) begin
        last_mul <= grant_mul;
      end
      if (div_req_val && div_req_rdy) begin
        div_signed_q <= div_signed;
      end
    end
  end

endmodule

//--- imuldiv_tb.sv
// ------------------------------
// testbench for imuldiv_top with a table of corner cases and random operands
// responses are checked by imuldiv_checker
// ------------------------------

`timescale 1ns/1ps
`include "imuldiv_consts.svh"

module imuldiv_tb;

  localparam int N_TESTS = 24;
  // 80 cycles of 100 ns per table entry
  localparam int TIMEOUT_NS = N_TESTS * 80 * 100;

  logic                     clk;
  logic                     reset;
  imuldiv_pkg::muldiv_op_e  req_op;
  logic [`IMULDIV_XLEN-1:0] req_a;
  logic [`IMULDIV_XLEN-1:0] req_b;
  logic                     req_val;
  logic                     req_rdy;
  imuldiv_pkg::muldiv_op_e  resp_op;
  logic [`IMULDIV_RLEN-1:0] resp_result;
  logic                     resp_val;
  logic                     resp_rdy;
  // holds resp_rdy low so both units can finish and wait together
  logic                     hold_resp;
  int                       resp_count;
  int                       err_count;
  int                       seed_ret;

  // stimulus table where hold_tab stalls the response port after that entry
  imuldiv_pkg::muldiv_op_e  op_tab   [N_TESTS];
  logic [`IMULDIV_XLEN-1:0] a_tab    [N_TESTS];
  logic [`IMULDIV_XLEN-1:0] b_tab    [N_TESTS];
  logic                     hold_tab [N_TESTS];

  imuldiv_top uut (
    .clk         (clk),
    .reset       (reset),
    .req_op      (req_op),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_op     (resp_op),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  // monitor also sees which units sit in ST_DONE
  imuldiv_checker chk (
    .clk         (clk),
    .reset       (reset),
    .req_op      (req_op),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_op     (resp_op),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .mul_done    (uut.mul_resp_val),
    .div_done    (uut.div_resp_val),
    .resp_count  (resp_count),
    .err_count   (err_count)
  );

  always #50 clk = ~clk;

  // random back-pressure with ready three cycles in four
  always @(posedge clk) begin
    if (reset || hold_resp) resp_rdy <= 1'b0;
    else resp_rdy <= ($urandom % 4) != 0;
  end

  task automatic set_entry(input int idx, input imuldiv_pkg::muldiv_op_e op,
                           input logic [31:0] a, input logic [31:0] b, input logic hold);
    op_tab[idx]   = op;
    a_tab[idx]    = a;
    b_tab[idx]    = b;
    hold_tab[idx] = hold;
  endtask

  task automatic load_table();
    int i;
    // ------------------------------
    // fixed corner cases
    // ------------------------------
    // mul then div with the port stalled so both units finish together
    set_entry(0, imuldiv_pkg::OP_MUL, 32'h0000_0007, 32'hFFFF_FFFD, 1'b0);
    set_entry(1, imuldiv_pkg::OP_DIV, 32'hFFFF_FF9C, 32'h0000_0007, 1'b1);
    // most negative times -1
    set_entry(2, imuldiv_pkg::OP_MUL, 32'h8000_0000, 32'hFFFF_FFFF, 1'b0);
    set_entry(3, imuldiv_pkg::OP_MUL, 32'h0000_0000, 32'h1234_5678, 1'b0);
    // stall after a lone mul response so the divider must win first
    set_entry(4, imuldiv_pkg::OP_DIV, 32'h0000_0064, 32'hFFFF_FFF9, 1'b1);
    // signed overflow divide
    set_entry(5, imuldiv_pkg::OP_DIV, 32'h8000_0000, 32'hFFFF_FFFF, 1'b0);
    set_entry(6, imuldiv_pkg::OP_DIVU, 32'hFFFF_FFFF, 32'h0000_0010, 1'b0);
    // unsigned and signed divide by zero
    set_entry(7, imuldiv_pkg::OP_DIVU, 32'h1234_5678, 32'h0000_0000, 1'b0);
    set_entry(8, imuldiv_pkg::OP_DIV, 32'hFFFF_FF85, 32'h0000_0000, 1'b0);
    set_entry(9, imuldiv_pkg::OP_MUL, 32'h7FFF_FFFF, 32'h7FFF_FFFF, 1'b0);
    // another stall with both units done
    set_entry(10, imuldiv_pkg::OP_MUL, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 1'b0);
    set_entry(11, imuldiv_pkg::OP_DIV, 32'h7FFF_FFFF, 32'h0000_0003, 1'b1);
    // random operands with small divisors now and then so zero shows up
    for (i = 12; i < N_TESTS; i++) begin
      op_tab[i]   = imuldiv_pkg::muldiv_op_e'(2'($urandom % 3));
      a_tab[i]    = $urandom;
      b_tab[i]    = $urandom;
      hold_tab[i] = 1'b0;
      if ($urandom % 4 == 0) b_tab[i] = b_tab[i] % 16;
    end
  endtask

  initial begin
    int i;
    clk       = 1'b0;
    reset     = 1'b1;
    req_op    = imuldiv_pkg::OP_MUL;
    req_a     = '0;
    req_b     = '0;
    req_val   = 1'b0;
    resp_rdy  = 1'b0;
    hold_resp = 1'b0;
    seed_ret  = $urandom(33303);
    load_table();
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    for (i = 0; i < N_TESTS; i++) begin
      req_op  <= op_tab[i];
      req_a   <= a_tab[i];
      req_b   <= b_tab[i];
      req_val <= 1'b1;
      // accepted at the first edge that sees req_rdy high
      @(posedge clk);
      while (!req_rdy) @(posedge clk);
      if (hold_tab[i]) begin
        req_val   <= 1'b0;
        hold_resp <= 1'b1;
        // long enough for a full 33 cycle operation in each unit
        repeat (`IMULDIV_STEPS + 8) @(posedge clk);
        hold_resp <= 1'b0;
      end
    end
    req_val <= 1'b0;
    wait (resp_count == N_TESTS);
    // a few more cycles to catch any extra response
    repeat (4) @(posedge clk);
    chk.report_summary();
    if (err_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("timeout: run did not finish in %0d ns, %0d of %0d responses seen",
             TIMEOUT_NS, resp_count, N_TESTS);
    chk.report_summary();
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

//--- imuldiv_top.sv
// ------------------------------
// multiply/divide subsystem top level
// one val/rdy request port in, one shared val/rdy response port out
// ------------------------------

`timescale 1ns/1ps
`include "imuldiv_consts.svh"

module imuldiv_top (
  input  logic                     clk,
  input  logic                     reset,
  input  imuldiv_pkg::muldiv_op_e  req_op,
  input  logic [`IMULDIV_XLEN-1:0] req_a,
  input  logic [`IMULDIV_XLEN-1:0] req_b,
  input  logic                     req_val,
  output logic                     req_rdy,
  output imuldiv_pkg::muldiv_op_e  resp_op,
  output logic [`IMULDIV_RLEN-1:0] resp_result,
  output logic                     resp_val,
  input  logic                     resp_rdy
);

  // per-unit request handshakes
  logic mul_req_val;
  logic mul_req_rdy;
  logic div_req_val;
  logic div_req_rdy;
  logic div_signed;

  // per-unit response handshakes
  logic                     mul_resp_val;
  logic                     mul_resp_rdy;
  logic [`IMULDIV_RLEN-1:0] mul_resp_result;
  logic                     div_resp_val;
  logic                     div_resp_rdy;
  logic [`IMULDIV_RLEN-1:0] div_resp_result;

  imuldiv_port_mux port_mux (
    .clk             (clk),
    .reset           (reset),
    .req_op          (req_op),
    .req_val         (req_val),
    .req_rdy         (req_rdy),
    .mul_req_val     (mul_req_val),
    .mul_req_rdy     (mul_req_rdy),
    .div_req_val     (div_req_val),
    .div_req_rdy     (div_req_rdy),
    .div_signed      (div_signed),
    .mul_resp_val    (mul_resp_val),
    .mul_resp_result (mul_resp_result),
    .mul_resp_rdy    (mul_resp_rdy),
    .div_resp_val    (div_resp_val),
    .div_resp_result (div_resp_result),
    .div_resp_rdy    (div_resp_rdy),
    .resp_val        (resp_val),
    .resp_rdy        (resp_rdy),
    .resp_op         (resp_op),
    .resp_result     (resp_result)
  );

  // operands fan out to both units, only the steered one sees val
  imuldiv_mul_iterative mul_unit (
    .clk         (clk),
    .reset       (reset),
    .req_val     (mul_req_val),
    .req_rdy     (mul_req_rdy),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (mul_resp_val),
    .resp_rdy    (mul_resp_rdy),
    .resp_result (mul_resp_result)
  );

  imuldiv_div_iterative div_unit (
    .clk         (clk),
    .reset       (reset),
    .req_val     (div_req_val),
    .req_rdy     (div_req_rdy),
    .req_a       (req_a),
    .req_b       (req_b),
    .div_signed  (div_signed),
    .resp_val    (div_resp_val),
    .resp_rdy    (div_resp_rdy),
    .resp_result (div_resp_result)
  );

endmodule

//--- verilog.f
+incdir+.
imuldiv_pkg.sv
imuldiv_mul_iterative.sv
imuldiv_div_iterative.sv
imuldiv_port_mux.sv
imuldiv_top.sv
imuldiv_checker.sv
imuldiv_tb.sv
